// File: mac_config.svh
// widths and depths shared by the MAC engine
// the multiplier datapath is built for 8-bit operands only
// queue depth must be a power of two

`ifndef MAC_CONFIG_SVH
`define MAC_CONFIG_SVH

// operand width, feature and weight
`define MAC_DATA_W 8

// accumulator and running sum width
`define MAC_ACC_W 28

`define MAC_FRAC_SHIFT 6   // bias shift, also low bit of the output byte

`define MAC_IN_DEPTH 4     // input queue entries, sender credits after reset

`define MAC_OUT_CREDITS 2  // receiver credits assumed after reset

`endif

// File: mac_pkg.sv
// shared types of the MAC engine
// widths come from mac_config.svh

`default_nettype none

`include "mac_config.svh"

package mac_pkg;

  typedef logic signed [`MAC_DATA_W-1:0]   data_t;  // feature, weight or bias
  typedef logic signed [2*`MAC_DATA_W-1:0] prod_t;
  typedef logic signed [`MAC_ACC_W-1:0]    acc_t;

  // unsigned output byte, always 0..127
  typedef logic [`MAC_DATA_W-1:0] mac_result_t;

  // one input item as sent by the stream source
  typedef struct packed {
    data_t feature;
    data_t weight;
    logic  first;   // clears the accumulator
    logic  last;    // closes the group
    data_t bias;    // only used with last
  } mac_item_t;

  // item control that rides along the multiplier pipeline
  typedef struct packed {
    logic  valid;
    logic  first;
    logic  last;
    data_t bias;
  } mac_tag_t;

endpackage

`default_nettype wire

// File: cla_adder.sv
// carry-lookahead adder from 4-bit groups, WIDTH must be a multiple of 4
// carry-in is fixed at zero, carry-out is discarded

`default_nettype none

module cla_adder #(
  parameter int WIDTH = 28
) (
  input  wire  [WIDTH-1:0] a,
  input  wire  [WIDTH-1:0] b,
  output logic [WIDTH-1:0] sum
);

  localparam int NG = WIDTH / 4;

  logic [WIDTH-1:0] p, g;
  logic [WIDTH-1:0] bc;      // carry into each bit
  logic [NG-1:0]    gp, gg;  // group propagate / generate
  logic [NG:0]      gc;      // carry into each group

  assign p     = a ^ b;
  assign g     = a & b;
  assign gc[0] = 1'b0;

  for (genvar k = 0; k < NG; k++) begin : g_grp
    localparam int L = 4 * k;

    assign gp[k] = &p[L+3:L];
    assign gg[k] = g[L+3] | (g[L+2] & p[L+3]) | (g[L+1] & p[L+2] & p[L+3])
                 | (g[L] & p[L+1] & p[L+2] & p[L+3]);

    assign gc[k+1] = gg[k] | (gp[k] & gc[k]);  // group lookahead unit

    // ripple inside the group
    assign bc[L]   = gc[k];
    assign bc[L+1] = g[L]   | (p[L]   & bc[L]);
    assign bc[L+2] = g[L+1] | (p[L+1] & bc[L+1]);
    assign bc[L+3] = g[L+2] | (p[L+2] & bc[L+2]);
  end

  assign sum = p ^ bc;

endmodule

`default_nettype wire

// File: signed_mult_pipe.sv
// 8x8 signed multiplier, eight enabled stages from item to product
// works on magnitudes and restores the sign in the last stage

`default_nettype none

module signed_mult_pipe (
  input  wire                    clk,
  input  wire                    rstn,
  input  wire                    enable,
  input  wire mac_pkg::mac_item_t item,
  input  wire                    item_valid,
  output mac_pkg::prod_t         prod,
  output mac_pkg::mac_tag_t      tag
);

  logic [7:0]  a_mag, b_mag;
  logic        sign;
  logic [7:0]  pp_q   [8];  // gated partial products
  logic [5:0]  lsb2   [4];
  logic [5:0]  lsb2_q [4];
  logic [2:0]  hia2_q [4];
  logic [3:0]  hib2_q [4];
  logic [4:0]  msb3   [4];
  logic [9:0]  s3_q   [4];
  logic [7:0]  lsb4   [2];
  logic [7:0]  lsb4_q [2];
  logic [2:0]  hia4_q [2];
  logic [4:0]  hib4_q [2];
  logic [4:0]  msb5   [2];
  logic [11:0] s5_q   [2];
  logic [9:0]  lsb6, lsb6_q;
  logic [2:0]  hia6_q;
  logic [6:0]  hib6_q, msb7;
  logic [15:0] mag_q;       // unsigned product
  logic [6:0]  sign_q;      // sign for stages 1..7
  mac_pkg::prod_t    prod_q;
  mac_pkg::mac_tag_t tag_q [8];

  // -128 maps to 128, which still fits 8 unsigned bits
  assign a_mag = item.feature[7] ? ~item.feature + 8'd1 : item.feature;
  assign b_mag = item.weight[7]  ? ~item.weight + 8'd1  : item.weight;
  assign sign  = item.feature[7] ^ item.weight[7];

  //////////////////////////////////////////////////
  // reduction tree, each level split low / high
  //////////////////////////////////////////////////
  always_comb begin
    for (int j = 0; j < 4; j++) begin
      lsb2[j] = 6'(pp_q[2*j][4:0]) + 6'({pp_q[2*j+1][3:0], 1'b0});
      msb3[j] = 5'(hia2_q[j]) + 5'(hib2_q[j]) + 5'(lsb2_q[j][5]);
    end
    for (int k = 0; k < 2; k++) begin
      lsb4[k] = 8'(s3_q[2*k][6:0]) + 8'({s3_q[2*k+1][4:0], 2'b00});
      msb5[k] = 5'(hia4_q[k]) + hib4_q[k] + 5'(lsb4_q[k][7]);
    end
    lsb6 = 10'(s5_q[0][8:0]) + 10'({s5_q[1][4:0], 4'b0000});
    msb7 = 7'(hia6_q) + hib6_q + 7'(lsb6_q[9]);
  end

  always_ff @(posedge clk) begin
    if (enable) begin
      for (int i = 0; i < 8; i++) begin
        pp_q[i] <= b_mag[i] ? a_mag : 8'h00;   // stage 1
      end
      for (int j = 0; j < 4; j++) begin
        lsb2_q[j] <= lsb2[j];                  // stage 2
        hia2_q[j] <= pp_q[2*j][7:5];
        hib2_q[j] <= pp_q[2*j+1][7:4];
        s3_q[j]   <= {msb3[j], lsb2_q[j][4:0]};  // stage 3
      end
      for (int k = 0; k < 2; k++) begin
        lsb4_q[k] <= lsb4[k];                  // stage 4
        hia4_q[k] <= s3_q[2*k][9:7];
        hib4_q[k] <= s3_q[2*k+1][9:5];
        s5_q[k]   <= {msb5[k], lsb4_q[k][6:0]};  // stage 5
      end
      lsb6_q <= lsb6;                          // stage 6
      hia6_q <= s5_q[0][11:9];
      hib6_q <= s5_q[1][11:5];
      mag_q  <= {msb7, lsb6_q[8:0]};           // stage 7
      sign_q <= {sign_q[5:0], sign};
      prod_q <= sign_q[6] ? ~mag_q + 16'd1 : mag_q;  // stage 8
    end
  end

  // tag travels beside the data, only valid is cleared
  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int i = 0; i < 8; i++) begin
        tag_q[i].valid <= 1'b0;
      end
    end else if (enable) begin
      tag_q[0] <= '{valid: item_valid, first: item.first, last: item.last, bias: item.bias};
      for (int i = 1; i < 8; i++) begin
        tag_q[i] <= tag_q[i-1];
      end
    end
  end

  assign prod = prod_q;
  assign tag  = tag_q[7];

endmodule

`default_nettype wire

// File: mac_accumulator.sv
// running sum of products, restarted by first, reported on last
// bubbles in the pipeline leave the sum untouched

`default_nettype none

`include "mac_config.svh"

module mac_accumulator (
  input  wire                    clk,
  input  wire                    rstn,
  input  wire                    enable,
  input  wire mac_pkg::prod_t    prod,
  input  wire mac_pkg::mac_tag_t tag,
  output mac_pkg::acc_t          sum,
  output logic                   sum_valid,
  output mac_pkg::data_t         sum_bias
);

  mac_pkg::acc_t prod_ext, addend, next_sum;
  mac_pkg::acc_t sum_q;
  mac_pkg::data_t bias_q;
  logic          sum_valid_q;

  assign prod_ext = mac_pkg::acc_t'(prod);        // sign extend
  assign addend   = tag.first ? '0 : sum_q;

  cla_adder #(.WIDTH(`MAC_ACC_W)) u_acc_add (
    .a   (prod_ext),
    .b   (addend),
    .sum (next_sum)
  );

  always_ff @(posedge clk) begin
    if (!rstn) begin
      sum_valid_q <= 1'b0;
    end else if (enable) begin
      sum_valid_q <= tag.valid & tag.last;
    end
  end

  always_ff @(posedge clk) begin
    if (enable && tag.valid) begin
      sum_q  <= next_sum;
      bias_q <= tag.bias;
    end
  end

  assign sum       = sum_q;
  assign sum_valid = sum_valid_q;
  assign sum_bias  = bias_q;

endmodule

`default_nettype wire

// File: requantizer.sv
// adds the bias in the sum's fixed point, then clamps to 0..127
// purely combinational

`default_nettype none

`include "mac_config.svh"

module requantizer (
  input  wire mac_pkg::acc_t  sum,
  input  wire mac_pkg::data_t bias,
  output mac_pkg::mac_result_t result
);

  localparam int SAT_LO = `MAC_FRAC_SHIFT + `MAC_DATA_W - 1;   // first overflow bit
  localparam int EXT_W  = `MAC_ACC_W - `MAC_DATA_W - `MAC_FRAC_SHIFT;
  localparam mac_pkg::mac_result_t RES_MAX = {1'b0, {(`MAC_DATA_W-1){1'b1}}};

  mac_pkg::acc_t bias_ext;
  mac_pkg::acc_t total;

  assign bias_ext = {{EXT_W{bias[`MAC_DATA_W-1]}}, bias, {`MAC_FRAC_SHIFT{1'b0}}};

  cla_adder #(.WIDTH(`MAC_ACC_W)) u_bias_add (
    .a   (sum),
    .b   (bias_ext),
    .sum (total)
  );

  always_comb begin
    if (total[`MAC_ACC_W-1]) begin
      result = '0;                                  // negative
    end else if (|total[`MAC_ACC_W-2:SAT_LO]) begin
      result = RES_MAX;                             // too large
    end else begin
      result = {1'b0, total[SAT_LO-1:`MAC_FRAC_SHIFT]};
    end
  end

endmodule

`default_nettype wire

// File: credit_rx_buffer.sv
// input item queue, sender may only push while it holds a credit
// a push into a full queue is a sender error and is not guarded

`default_nettype none

`include "mac_config.svh"

module credit_rx_buffer (
  input  wire                     clk,
  input  wire                     rstn,
  input  wire                     in_valid,
  input  wire mac_pkg::mac_item_t in_item,
  input  wire                     enable,
  output mac_pkg::mac_item_t      head,
  output logic                    head_valid,
  output logic                    in_credit
);

  localparam int DEPTH = `MAC_IN_DEPTH;
  localparam int AW    = $clog2(DEPTH);

  typedef logic [AW-1:0] ptr_t;
  typedef logic [AW:0]   cnt_t;

  mac_pkg::mac_item_t mem [DEPTH];
  ptr_t wr_ptr, rd_ptr;
  cnt_t count;
  logic pop;
  logic credit_q;

  assign pop = enable && (count != '0);   // head taken by the multiplier

  always_ff @(posedge clk) begin
    if (in_valid) begin
      mem[wr_ptr] <= in_item;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      credit_q <= 1'b0;
    end else begin
      credit_q <= pop;                    // credit back one cycle after the pop
      if (in_valid) wr_ptr <= wr_ptr + ptr_t'(1);
      if (pop) rd_ptr <= rd_ptr + ptr_t'(1);
      case ({in_valid, pop})
        2'b10:   count <= count + cnt_t'(1);
        2'b01:   count <= count - cnt_t'(1);
        default: count <= count;
      endcase
    end
  end

  assign head       = mem[rd_ptr];
  assign head_valid = (count != '0);
  assign in_credit  = credit_q;

endmodule

`default_nettype wire

// File: credit_tx_port.sv
// one-entry result holder with receiver credit count
// receiver must never return more credits than it was granted

`default_nettype none

`include "mac_config.svh"

module credit_tx_port (
  input  wire                       clk,
  input  wire                       rstn,
  input  wire                       sum_valid,
  input  wire mac_pkg::mac_result_t result,
  input  wire                       res_credit,
  output logic                      res_valid,
  output mac_pkg::mac_result_t      res_data,
  output logic                      enable
);

  localparam int CW = $clog2(`MAC_OUT_CREDITS + 1) + 1;

  typedef logic [CW-1:0] credit_t;

  credit_t              credits;
  logic                 hold_full;
  mac_pkg::mac_result_t hold_data;
  logic                 send, load;

  assign send   = hold_full && (credits != '0);
  assign enable = !hold_full || (credits != '0);   // stall only when stuck
  assign load   = sum_valid && enable;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      hold_full <= 1'b0;
      credits   <= credit_t'(`MAC_OUT_CREDITS);
    end else begin
      if (load) hold_full <= 1'b1;
      else if (send) hold_full <= 1'b0;
      case ({res_credit, send})
        2'b10:   credits <= credits + credit_t'(1);
        2'b01:   credits <= credits - credit_t'(1);
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (load) hold_data <= result;
  end

  assign res_valid = send;
  assign res_data  = hold_data;

endmodule

`default_nettype wire

// File: conv_mac_top.sv
// stream MAC engine with credit flow control on both sides
// result appears 10 cycles after the last item leaves the queue, more on stalls

`default_nettype none

module conv_mac_top (
  input  wire                       clk,
  input  wire                       rstn,
  input  wire                       in_valid,
  input  wire mac_pkg::mac_item_t   in_item,
  output logic                      in_credit,
  output logic                      res_valid,
  output mac_pkg::mac_result_t      res_data,
  input  wire                       res_credit
);

  mac_pkg::mac_item_t   head;
  logic                 head_valid;
  logic                 enable;       // pipeline-wide stall, low freezes everything
  mac_pkg::prod_t       prod;
  mac_pkg::mac_tag_t    tag;
  mac_pkg::acc_t        sum;
  logic                 sum_valid;
  mac_pkg::data_t       sum_bias;
  mac_pkg::mac_result_t result;

  credit_rx_buffer u_rx (
    .clk, .rstn, .in_valid, .in_item, .enable,
    .head, .head_valid, .in_credit
  );

  signed_mult_pipe u_mult (
    .clk, .rstn, .enable,
    .item (head), .item_valid (head_valid), .prod, .tag
  );

  mac_accumulator u_acc (
    .clk, .rstn, .enable, .prod, .tag,
    .sum, .sum_valid, .sum_bias
  );

  requantizer u_rq (.sum, .bias (sum_bias), .result);

  credit_tx_port u_tx (
    .clk, .rstn, .sum_valid, .result, .res_credit,
    .res_valid, .res_data, .enable
  );

endmodule

`default_nettype wire

// File: conv_mac_asserts.sv
// port protocol checks for conv_mac_top, attached with bind
// receiver credits are rebuilt here from res_valid and res_credit

`default_nettype none

`include "mac_config.svh"

module conv_mac_asserts (
  input wire clk,
  input wire rstn,
  input wire in_valid,
  input wire in_credit,
  input wire res_valid,
  input wire res_credit
);

  int port_credits;        // receiver credits as seen on the ports
  int items_in;
  int credits_back;
  int credit_fails = 0;
  int reset_fails  = 0;
  int return_fails = 0;
  int fail_count;

  assign fail_count = credit_fails + reset_fails + return_fails;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      port_credits <= `MAC_OUT_CREDITS;
      items_in     <= 0;
      credits_back <= 0;
    end else begin
      port_credits <= port_credits + int'(res_credit) - int'(res_valid);
      items_in     <= items_in + int'(in_valid);
      credits_back <= credits_back + int'(in_credit);
    end
  end

  a_res_credit: assert property (@(posedge clk) disable iff (!rstn)
    res_valid |-> port_credits > 0)
    else begin
      $error("res_valid raised with no receiver credit left");
      credit_fails++;
    end

  a_reset_quiet: assert property (@(posedge clk)
    $rose(rstn) |-> !in_credit && !res_valid)
    else begin
      $error("in_credit or res_valid high right after reset");
      reset_fails++;
    end

  // a credit can only come back for an item that went in
  a_credit_return: assert property (@(posedge clk) disable iff (!rstn)
    in_credit |-> credits_back < items_in)
    else begin
      $error("more input credits returned than items received");
      return_fails++;
    end

endmodule

bind conv_mac_top conv_mac_asserts u_chk (
  .clk        (clk),
  .rstn       (rstn),
  .in_valid   (in_valid),
  .in_credit  (in_credit),
  .res_valid  (res_valid),
  .res_credit (res_credit)
);

`default_nettype wire

// File: conv_mac_tb.sv
// self-checking testbench for conv_mac_top
// output credits are only returned for results already received

`default_nettype none

`include "mac_config.svh"

module conv_mac_tb;

  localparam int WAIT_LIMIT = 2000;   // cycles allowed per wait loop
  localparam int MAX_ITEMS  = 12;

  logic                 clk;
  logic                 rstn;
  logic                 in_valid;
  mac_pkg::mac_item_t   in_item;
  logic                 in_credit;
  logic                 res_valid;
  mac_pkg::mac_result_t res_data;
  logic                 res_credit;

  int seed = 97199;
  int credit_seed;
  int feat [MAX_ITEMS];
  int wt   [MAX_ITEMS];
  mac_pkg::mac_result_t exp_q [$];
  mac_pkg::mac_result_t expected;

  int in_used = 0;          // items pushed by the sender
  int in_returned = 0;      // in_credit pulses seen
  int results_seen = 0;
  int credits_given = 0;
  int cycle = 0;
  int hold_end = 0;         // no output credits until this cycle
  int credit_mode = 0;      // 0 prompt, 1 random
  int groups_sent = 0;
  int mismatch_errors = 0;
  int protocol_errors = 0;
  int stall_errors = 0;
  int timeout_errors = 0;
  int count_errors = 0;
  int total_errors;
  bit aborted = 1'b0;

  conv_mac_top uut (
    .clk, .rstn, .in_valid, .in_item, .in_credit,
    .res_valid, .res_data, .res_credit
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // expected byte from the group's pairs and bias
  function automatic mac_pkg::mac_result_t expected_byte(input int f [MAX_ITEMS],
                                                         input int w [MAX_ITEMS],
                                                         input int n, input int bias);
    longint total;
    total = longint'(bias) * 64;
    for (int i = 0; i < n; i++) begin
      total += longint'(f[i] * w[i]);
    end
    if (total < 0) begin
      return '0;
    end else if (total >= 8192) begin
      return 8'd127;                           // above seven bits
    end
    return mac_pkg::mac_result_t'(total / 64);
  endfunction

  task automatic set_pair(input int i, input int f, input int w);
    feat[i] = f;
    wt[i]   = w;
  endtask

  task automatic send_item(input int f, input int w, input bit first, input bit last,
                           input int bias);
    int waited;
    waited = 0;
    while (!aborted && (in_used - in_returned >= `MAC_IN_DEPTH)) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited >= WAIT_LIMIT) begin
        $display("timeout: no input credit came back within %0d cycles", WAIT_LIMIT);
        timeout_errors++;
        aborted = 1'b1;
      end
    end
    if (!aborted) begin
      in_item.feature = mac_pkg::data_t'(f);
      in_item.weight  = mac_pkg::data_t'(w);
      in_item.first   = first;
      in_item.last    = last;
      in_item.bias    = mac_pkg::data_t'(bias);
      in_valid        = 1'b1;
      in_used++;
      @(posedge clk);
      #1;
      in_valid = 1'b0;
    end
  endtask

  task automatic send_group(input int n, input int bias);
    exp_q.push_back(expected_byte(feat, wt, n, bias));
    groups_sent++;
    for (int i = 0; i < n; i++) begin
      send_item(feat[i], wt[i], i == 0, i == n - 1, bias);
    end
  endtask

  task automatic random_group(input int n, input bit scaled);
    int bias;
    for (int i = 0; i < n; i++) begin
      feat[i] = int'(mac_pkg::data_t'($random(seed)));
      wt[i]   = int'(mac_pkg::data_t'($random(seed)));
      if (scaled) feat[i] = feat[i] / 8;   // keeps sums in the unclamped range
    end
    bias = int'(mac_pkg::data_t'($random(seed)));
    if (scaled) bias = bias / 16;
    send_group(n, bias);
  endtask

  task automatic wait_for_results();
    int waited;
    waited = 0;
    while (!aborted && exp_q.size() != 0) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited >= WAIT_LIMIT) begin
        $display("timeout: %0d results still missing after %0d cycles",
                 exp_q.size(), WAIT_LIMIT);
        timeout_errors++;
        aborted = 1'b1;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // output side, compare and credit return
  //////////////////////////////////////////////////
  always @(negedge clk) begin
    if (rstn) begin
      if (in_credit) in_returned++;
      assert (in_used - in_returned >= 0 && in_used - in_returned <= `MAC_IN_DEPTH)
        else begin
          $display("sender holds %0d items beyond its credit", in_used - in_returned);
          protocol_errors++;
        end
      if (res_valid) begin
        if (exp_q.size() == 0) begin
          $display("result 0x%h arrived with no group outstanding", res_data);
          protocol_errors++;
        end else begin
          expected = exp_q.pop_front();
          assert (res_data === expected)
            else begin
              $display("Mismatch: res_data got 0x%h expected 0x%h", res_data, expected);
              mismatch_errors++;
            end
        end
        results_seen++;
        assert (results_seen - credits_given <= `MAC_OUT_CREDITS)
          else begin
            $display("more results sent than output credits granted");
            protocol_errors++;
          end
      end
    end
  end

  initial begin : credit_return
    logic give;
    res_credit  = 1'b0;
    credit_seed = seed + 1;                  // own stream for credit returns
    forever begin
      @(posedge clk);
      give = 1'b0;
      cycle++;
      if (cycle == hold_end) begin
        assert (results_seen - credits_given == `MAC_OUT_CREDITS &&
                in_used - in_returned == `MAC_IN_DEPTH)
          else begin
            $display("withheld credits did not stall the engine and the sender");
            stall_errors++;
          end
      end
      if (cycle > hold_end && results_seen > credits_given) begin
        give = (credit_mode == 0) || (($random(credit_seed) & 1) == 1);
      end
      #1;
      res_credit = give;
      if (give) credits_given++;
    end
  end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////
  initial begin
    rstn     = 1'b0;
    in_valid = 1'b0;
    in_item  = '0;
    repeat (2) @(posedge clk);
    #1;
    rstn = 1'b1;
    @(posedge clk);
    #1;

    set_pair(0, 20, 10);                     // single item, 200 >> 6
    send_group(1, 0);
    wait_for_results();

    set_pair(0, -128, -128);                 // nine mixed signs
    set_pair(1, 100, -50);
    set_pair(2, -70, 33);
    set_pair(3, 127, 1);
    set_pair(4, -3, -4);
    set_pair(5, 55, -60);
    set_pair(6, -128, -20);
    set_pair(7, 90, -40);
    set_pair(8, 12, -7);
    send_group(9, -5);
    wait_for_results();

    set_pair(0, 127, 127);                   // clamps high
    set_pair(1, 127, 127);
    send_group(2, 3);
    set_pair(0, -100, 50);                   // clamps low
    send_group(1, 10);
    wait_for_results();

    hold_end = cycle + 100;                  // receiver goes silent
    for (int g = 0; g < 10; g++) begin
      random_group(3, 1'b1);
    end
    wait_for_results();

    credit_mode = 1;
    for (int g = 0; g < 40; g++) begin
      random_group(1 + (($random(seed) & 32'h7fff) % MAX_ITEMS), g[0]);
    end
    wait_for_results();

    assert (results_seen == groups_sent)
      else begin
        $display("%0d results for %0d groups", results_seen, groups_sent);
        count_errors++;
      end

    total_errors = mismatch_errors + protocol_errors + stall_errors + timeout_errors
                 + count_errors + uut.u_chk.fail_count;
    $display("errors: mismatch %0d, protocol %0d, stall %0d, timeout %0d, count %0d, assert %0d",
             mismatch_errors, protocol_errors, stall_errors, timeout_errors, count_errors,
             uut.u_chk.fail_count);
    if (total_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+.
mac_pkg.sv
cla_adder.sv
signed_mult_pipe.sv
mac_accumulator.sv
requantizer.sv
credit_rx_buffer.sv
credit_tx_port.sv
conv_mac_top.sv
conv_mac_asserts.sv
conv_mac_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the MAC engine simulation with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --top-module conv_mac_tb -f flist.f; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vconv_mac_tb +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qF '*** TEST PASSED ***' "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
